/* design/systolic_pkg.sv */
// array sizes, data and accumulator widths, end-of-count values, opcode and run state enums
package systolic_pkg;

    // array dimension N
    localparam int SYSTOLIC_UNIT_NUM = 4;

    // one matrix element
    localparam int DATA_WIDTH = 8;

    // one packed slice, N elements side by side
    localparam int SYSTOLIC_DATA_WIDTH = SYSTOLIC_UNIT_NUM * DATA_WIDTH;

    // 4 * 255 * 255 fits with room to spare
    localparam int ACC_WIDTH = 20;

    localparam int ELEM_NUM  = SYSTOLIC_UNIT_NUM * SYSTOLIC_UNIT_NUM;
    localparam int ADDR_SIZE = 4;

    // all accumulators, row-major, element 0 in the low bits
    localparam int ACC_FLAT_WIDTH = ELEM_NUM * ACC_WIDTH;

    // skew clears 2N-1 shifts after the last slice
    localparam int FLUSH_CYCLES = 2 * SYSTOLIC_UNIT_NUM - 1;

    localparam int SLICE_CNT_WIDTH = $clog2(SYSTOLIC_UNIT_NUM);
    localparam int FLUSH_CNT_WIDTH = $clog2(FLUSH_CYCLES);

    // terminal counts, sized to their counters
    localparam logic [SLICE_CNT_WIDTH-1:0] LAST_SLICE =
        SLICE_CNT_WIDTH'(SYSTOLIC_UNIT_NUM - 1);
    localparam logic [FLUSH_CNT_WIDTH-1:0] LAST_FLUSH =
        FLUSH_CNT_WIDTH'(FLUSH_CYCLES - 1);
    localparam logic [ADDR_SIZE-1:0] LAST_INDEX = ADDR_SIZE'(ELEM_NUM - 1);

    // host command opcodes
    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_LOAD_A = 2'd1,
        OP_LOAD_B = 2'd2,
        OP_START  = 2'd3
    } mm_op_e;

    // run phases
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FEED  = 2'd1,
        ST_FLUSH = 2'd2,
        ST_DRAIN = 2'd3
    } mm_state_e;

endpackage

/* design/mm_cmd_decode.sv */
// host command decoder with buffer write strobes, start pulse and busy tracking
`timescale 1ns/100ps

module mm_cmd_decode (
    input  logic                                s_clk,
    input  logic                                s_rst,
    input  logic                                cmd_valid,
    input  systolic_pkg::mm_op_e                cmd_op,
    input  logic [systolic_pkg::ADDR_SIZE-1:0]  cmd_addr,
    input  logic [systolic_pkg::DATA_WIDTH-1:0] cmd_data,
    input  logic                                res_last,
    output logic                                wr_a_en,
    output logic                                wr_b_en,
    output logic [systolic_pkg::ADDR_SIZE-1:0]  wr_addr,
    output logic [systolic_pkg::DATA_WIDTH-1:0] wr_data,
    output logic                                start,
    output logic                                busy
);

    systolic_pkg::mm_state_e run_state;
    logic                    accept;

    // commands only count between runs
    assign accept = cmd_valid && !busy;
    assign busy   = (run_state != systolic_pkg::ST_IDLE);

    // one-cycle strobes towards feeder and array
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_a_en <= 1'b0;
            wr_b_en <= 1'b0;
            start   <= 1'b0;
        end else begin
            wr_a_en <= 1'b0;
            wr_b_en <= 1'b0;
            start   <= 1'b0;
            if (accept) begin
                case (cmd_op)
                    systolic_pkg::OP_LOAD_A: wr_a_en <= 1'b1;
                    systolic_pkg::OP_LOAD_B: wr_b_en <= 1'b1;
                    systolic_pkg::OP_START:  start   <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // busy from accepted start until the last result
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            run_state <= systolic_pkg::ST_IDLE;
        end else if (accept && cmd_op == systolic_pkg::OP_START) begin
            run_state <= systolic_pkg::ST_FEED;
        end else if (res_last) begin
            run_state <= systolic_pkg::ST_IDLE;
        end
    end

    // write address and byte, qualified by the strobes above
    always_ff @(posedge s_clk) begin
        if (accept) begin
            wr_addr <= cmd_addr;
            wr_data <= cmd_data;
        end
    end

endmodule

/* design/slice_feeder.sv */
// operand buffers for A and B and the two valid/ready/done slice streams
`timescale 1ns/100ps

module slice_feeder (
    input  logic                                         s_clk,
    input  logic                                         s_rst,
    input  logic                                         wr_a_en,
    input  logic                                         wr_b_en,
    input  logic [systolic_pkg::ADDR_SIZE-1:0]           wr_addr,
    input  logic [systolic_pkg::DATA_WIDTH-1:0]          wr_data,
    input  logic                                         start,
    input  logic                                         a_slice_ready,
    input  logic                                         b_slice_ready,
    output logic                                         a_slice_valid,
    output logic [systolic_pkg::SYSTOLIC_DATA_WIDTH-1:0] a_slice_data,
    output logic                                         a_slice_done,
    output logic                                         b_slice_valid,
    output logic [systolic_pkg::SYSTOLIC_DATA_WIDTH-1:0] b_slice_data,
    output logic                                         b_slice_done
);

    // row-major element store, index i*N+k
    logic [systolic_pkg::DATA_WIDTH-1:0] mem_a [systolic_pkg::ELEM_NUM];
    logic [systolic_pkg::DATA_WIDTH-1:0] mem_b [systolic_pkg::ELEM_NUM];

    // stream 0 carries A, stream 1 carries B
    logic [1:0]                                 slice_valid;
    logic [1:0]                                 slice_ready;
    logic [systolic_pkg::SLICE_CNT_WIDTH-1:0]   slice_cnt [2];

    always_ff @(posedge s_clk) begin
        if (wr_a_en) begin
            mem_a[wr_addr] <= wr_data;
        end
        if (wr_b_en) begin
            mem_b[wr_addr] <= wr_data;
        end
    end

    assign slice_ready = {b_slice_ready, a_slice_ready};

    // each stream walks k = 0..N-1, one step per accepted slice
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            for (int s = 0; s < 2; s++) begin
                slice_valid[s] <= 1'b0;
                slice_cnt[s]   <= '0;
            end
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (start) begin
                    slice_valid[s] <= 1'b1;
                    slice_cnt[s]   <= '0;
                end else if (slice_valid[s] && slice_ready[s]) begin
                    slice_cnt[s] <= slice_cnt[s] + 1'b1;
                    if (slice_cnt[s] == systolic_pkg::LAST_SLICE) begin
                        slice_valid[s] <= 1'b0;
                    end
                end
            end
        end
    end

    assign a_slice_valid = slice_valid[0];
    assign b_slice_valid = slice_valid[1];
    assign a_slice_done  = slice_valid[0] && (slice_cnt[0] == systolic_pkg::LAST_SLICE);
    assign b_slice_done  = slice_valid[1] && (slice_cnt[1] == systolic_pkg::LAST_SLICE);

    // column k of A and row k of B, lane i in bits i*8 upwards
    always_comb begin
        for (int i = 0; i < systolic_pkg::SYSTOLIC_UNIT_NUM; i++) begin
            a_slice_data[i*systolic_pkg::DATA_WIDTH +: systolic_pkg::DATA_WIDTH] =
                mem_a[i * systolic_pkg::SYSTOLIC_UNIT_NUM + int'(slice_cnt[0])];
            b_slice_data[i*systolic_pkg::DATA_WIDTH +: systolic_pkg::DATA_WIDTH] =
                mem_b[int'(slice_cnt[1]) * systolic_pkg::SYSTOLIC_UNIT_NUM + i];
        end
    end

endmodule

/* design/pe_array.sv */
// run FSM, input skew registers and the N x N grid of multiply-accumulate cells
`timescale 1ns/100ps

module pe_array (
    input  logic                                         s_clk,
    input  logic                                         s_rst,
    input  logic                                         start,
    input  logic                                         a_slice_valid,
    input  logic [systolic_pkg::SYSTOLIC_DATA_WIDTH-1:0] a_slice_data,
    input  logic                                         a_slice_done,
    input  logic                                         b_slice_valid,
    input  logic [systolic_pkg::SYSTOLIC_DATA_WIDTH-1:0] b_slice_data,
    output logic                                         a_slice_ready,
    output logic                                         b_slice_ready,
    output logic [systolic_pkg::ACC_FLAT_WIDTH-1:0]      acc_flat,
    output logic                                         acc_done
);

    systolic_pkg::mm_state_e                    state;
    logic [systolic_pkg::FLUSH_CNT_WIDTH-1:0]   flush_cnt;
    logic                                       xfer;
    logic                                       shift;

    // skewed operands at the grid edge
    logic [systolic_pkg::DATA_WIDTH-1:0] a_edge [systolic_pkg::SYSTOLIC_UNIT_NUM];
    logic [systolic_pkg::DATA_WIDTH-1:0] b_edge [systolic_pkg::SYSTOLIC_UNIT_NUM];

    // operands passed right (A) and down (B), plus the accumulators
    logic [systolic_pkg::DATA_WIDTH-1:0]
        a_q [systolic_pkg::SYSTOLIC_UNIT_NUM][systolic_pkg::SYSTOLIC_UNIT_NUM];
    logic [systolic_pkg::DATA_WIDTH-1:0]
        b_q [systolic_pkg::SYSTOLIC_UNIT_NUM][systolic_pkg::SYSTOLIC_UNIT_NUM];
    logic [systolic_pkg::ACC_WIDTH-1:0]
        acc_q [systolic_pkg::SYSTOLIC_UNIT_NUM][systolic_pkg::SYSTOLIC_UNIT_NUM];

    // both slices move together, one step per cycle
    assign xfer          = (state == systolic_pkg::ST_FEED) && a_slice_valid && b_slice_valid;
    assign a_slice_ready = xfer;
    assign b_slice_ready = xfer;
    assign shift         = xfer || (state == systolic_pkg::ST_FLUSH);
    assign acc_done      = (state == systolic_pkg::ST_DRAIN);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state     <= systolic_pkg::ST_IDLE;
            flush_cnt <= '0;
        end else if (start) begin
            state     <= systolic_pkg::ST_FEED;
            flush_cnt <= '0;
        end else begin
            case (state)
                systolic_pkg::ST_FEED: begin
                    if (xfer && a_slice_done) begin
                        state <= systolic_pkg::ST_FLUSH;
                    end
                end
                systolic_pkg::ST_FLUSH: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == systolic_pkg::LAST_FLUSH) begin
                        state <= systolic_pkg::ST_DRAIN;
                    end
                end
                // single-cycle acc_done
                systolic_pkg::ST_DRAIN: state <= systolic_pkg::ST_IDLE;
                default: ;
            endcase
        end
    end

    // row i of A and column i of B share one delay chain of i stages
    for (genvar i = 0; i < systolic_pkg::SYSTOLIC_UNIT_NUM; i++) begin : g_skew
        logic [2*systolic_pkg::DATA_WIDTH-1:0] pair_in;

        // zeros go in while flushing
        assign pair_in = xfer ?
            {a_slice_data[i*systolic_pkg::DATA_WIDTH +: systolic_pkg::DATA_WIDTH],
             b_slice_data[i*systolic_pkg::DATA_WIDTH +: systolic_pkg::DATA_WIDTH]} : '0;

        if (i == 0) begin : g_direct
            assign {a_edge[i], b_edge[i]} = pair_in;
        end else begin : g_delay
            logic [2*systolic_pkg::DATA_WIDTH-1:0] dly [i];

            always_ff @(posedge s_clk) begin
                if (start) begin
                    for (int d = 0; d < i; d++) begin
                        dly[d] <= '0;
                    end
                end else if (shift) begin
                    dly[0] <= pair_in;
                    for (int d = 1; d < i; d++) begin
                        dly[d] <= dly[d-1];
                    end
                end
            end

            assign {a_edge[i], b_edge[i]} = dly[i-1];
        end
    end

    // cell (i,j) meets A(i,k) and B(k,j) on shift i+j+k
    for (genvar i = 0; i < systolic_pkg::SYSTOLIC_UNIT_NUM; i++) begin : g_row
        for (genvar j = 0; j < systolic_pkg::SYSTOLIC_UNIT_NUM; j++) begin : g_col
            logic [systolic_pkg::DATA_WIDTH-1:0]   a_in;
            logic [systolic_pkg::DATA_WIDTH-1:0]   b_in;
            logic [2*systolic_pkg::DATA_WIDTH-1:0] prod;

            if (j == 0) begin : g_a_edge
                assign a_in = a_edge[i];
            end else begin : g_a_pass
                assign a_in = a_q[i][j-1];
            end

            if (i == 0) begin : g_b_edge
                assign b_in = b_edge[j];
            end else begin : g_b_pass
                assign b_in = b_q[i-1][j];
            end

            assign prod = {{systolic_pkg::DATA_WIDTH{1'b0}}, a_in} *
                          {{systolic_pkg::DATA_WIDTH{1'b0}}, b_in};

            always_ff @(posedge s_clk) begin
                if (start) begin
                    a_q[i][j]   <= '0;
                    b_q[i][j]   <= '0;
                    acc_q[i][j] <= '0;
                end else if (shift) begin
                    a_q[i][j]   <= a_in;
                    b_q[i][j]   <= b_in;
                    acc_q[i][j] <= acc_q[i][j] +
                        {{(systolic_pkg::ACC_WIDTH - 2*systolic_pkg::DATA_WIDTH){1'b0}}, prod};
                end
            end

            assign acc_flat[(i*systolic_pkg::SYSTOLIC_UNIT_NUM + j)*systolic_pkg::ACC_WIDTH
                            +: systolic_pkg::ACC_WIDTH] = acc_q[i][j];
        end
    end

endmodule

/* design/result_drain.sv */
// accumulator capture and serial result output with index and last
`timescale 1ns/100ps

module result_drain (
    input  logic                                    s_clk,
    input  logic                                    s_rst,
    input  logic [systolic_pkg::ACC_FLAT_WIDTH-1:0] acc_flat,
    input  logic                                    acc_done,
    output logic                                    res_valid,
    output logic [systolic_pkg::ACC_WIDTH-1:0]      res_data,
    output logic [systolic_pkg::ADDR_SIZE-1:0]      res_index,
    output logic                                    res_last
);

    // snapshot frees the array for the next start
    logic [systolic_pkg::ACC_FLAT_WIDTH-1:0] hold;
    logic [systolic_pkg::ADDR_SIZE-1:0]      idx;
    logic                                    active;

    always_ff @(posedge s_clk) begin
        if (acc_done) begin
            hold <= acc_flat;
        end
    end

    // index walks 0..ELEM_NUM-1 with no gaps
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (acc_done) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (active) begin
            idx <= idx + 1'b1;
            if (idx == systolic_pkg::LAST_INDEX) begin
                active <= 1'b0;
            end
        end
    end

    assign res_valid = active;
    assign res_index = idx;
    assign res_last  = active && (idx == systolic_pkg::LAST_INDEX);
    // row-major, so index i*N+j selects C(i,j)
    assign res_data  = hold[idx*systolic_pkg::ACC_WIDTH +: systolic_pkg::ACC_WIDTH];

endmodule

/* design/systolic_top.sv */
// top level with command decode, slice feeder, PE array and result drain
`timescale 1ns/100ps

module systolic_top (
    input  logic                                s_clk,
    input  logic                                s_rst,
    input  logic                                cmd_valid,
    input  systolic_pkg::mm_op_e                cmd_op,
    input  logic [systolic_pkg::ADDR_SIZE-1:0]  cmd_addr,
    input  logic [systolic_pkg::DATA_WIDTH-1:0] cmd_data,
    output logic                                busy,
    output logic                                res_valid,
    output logic [systolic_pkg::ACC_WIDTH-1:0]  res_data,
    output logic [systolic_pkg::ADDR_SIZE-1:0]  res_index,
    output logic                                res_last
);

    logic                                         wr_a_en;
    logic                                         wr_b_en;
    logic [systolic_pkg::ADDR_SIZE-1:0]           wr_addr;
    logic [systolic_pkg::DATA_WIDTH-1:0]          wr_data;
    logic                                         start;

    // slice streams between feeder and array
    logic                                         a_slice_valid;
    logic [systolic_pkg::SYSTOLIC_DATA_WIDTH-1:0] a_slice_data;
    logic                                         a_slice_done;
    logic                                         a_slice_ready;
    logic                                         b_slice_valid;
    logic [systolic_pkg::SYSTOLIC_DATA_WIDTH-1:0] b_slice_data;
    logic                                         b_slice_done;
    logic                                         b_slice_ready;

    logic [systolic_pkg::ACC_FLAT_WIDTH-1:0]      acc_flat;
    logic                                         acc_done;

    mm_cmd_decode u_decode (
        .s_clk, .s_rst, .cmd_valid, .cmd_op, .cmd_addr, .cmd_data, .res_last,
        .wr_a_en, .wr_b_en, .wr_addr, .wr_data, .start, .busy
    );

    slice_feeder u_feeder (
        .s_clk, .s_rst, .wr_a_en, .wr_b_en, .wr_addr, .wr_data, .start,
        .a_slice_ready, .b_slice_ready,
        .a_slice_valid, .a_slice_data, .a_slice_done,
        .b_slice_valid, .b_slice_data, .b_slice_done
    );

    // the A done flag alone ends the feed
    pe_array u_array (
        .s_clk, .s_rst, .start,
        .a_slice_valid, .a_slice_data, .a_slice_done,
        .b_slice_valid, .b_slice_data,
        .a_slice_ready, .b_slice_ready, .acc_flat, .acc_done
    );

    result_drain u_drain (
        .s_clk, .s_rst, .acc_flat, .acc_done,
        .res_valid, .res_data, .res_index, .res_last
    );

endmodule

/* verification/systolic_properties.sv */
// slice handshake, busy framing and result framing assertions bound to systolic_top
`timescale 1ns/100ps

module systolic_properties (
    input logic                                         s_clk,
    input logic                                         s_rst,
    input logic                                         busy,
    input logic                                         a_slice_valid,
    input logic                                         a_slice_ready,
    input logic [systolic_pkg::SYSTOLIC_DATA_WIDTH-1:0] a_slice_data,
    input logic                                         a_slice_done,
    input logic                                         b_slice_valid,
    input logic                                         b_slice_ready,
    input logic [systolic_pkg::SYSTOLIC_DATA_WIDTH-1:0] b_slice_data,
    input logic                                         b_slice_done,
    input logic                                         res_valid,
    input logic [systolic_pkg::ADDR_SIZE-1:0]           res_index,
    input logic                                         res_last
);

    // number of failed checks so far
    int fail_count = 0;

    // a pending slice keeps valid and data until accepted
    a_hold: assert property (@(posedge s_clk) disable iff (s_rst)
        a_slice_valid && !a_slice_ready |=> a_slice_valid && $stable(a_slice_data))
        else begin $error("A slice changed before it was accepted"); fail_count++; end
    b_hold: assert property (@(posedge s_clk) disable iff (s_rst)
        b_slice_valid && !b_slice_ready |=> b_slice_valid && $stable(b_slice_data))
        else begin $error("B slice changed before it was accepted"); fail_count++; end

    idle_quiet: assert property (@(posedge s_clk) disable iff (s_rst)
        !busy |-> !(a_slice_valid || b_slice_valid || res_valid))
        else begin $error("stream or result active while not busy"); fail_count++; end

    done_valid: assert property (@(posedge s_clk) disable iff (s_rst)
        (a_slice_done || b_slice_done) |-> (a_slice_done -> a_slice_valid) &&
                                           (b_slice_done -> b_slice_valid))
        else begin $error("slice done without valid"); fail_count++; end

    // last result is index 15
    last_frame: assert property (@(posedge s_clk) disable iff (s_rst)
        res_last |-> res_valid && res_index == systolic_pkg::LAST_INDEX)
        else begin $error("res_last outside the final result"); fail_count++; end

endmodule

bind systolic_top systolic_properties u_props (.*);

/* verification/systolic_tb.sv */
// testbench for systolic_top with command tasks, reference product and per-test report
`timescale 1ns/100ps

module systolic_tb;

    localparam int N = systolic_pkg::SYSTOLIC_UNIT_NUM;
    // about 500 cycles over five tests (loads of 17, runs of about 31, idle checks)
    localparam int CYCLE_LIMIT = 2000;

    logic                                s_clk = 1'b0;
    logic                                s_rst;
    logic                                cmd_valid;
    systolic_pkg::mm_op_e                cmd_op;
    logic [systolic_pkg::ADDR_SIZE-1:0]  cmd_addr;
    logic [systolic_pkg::DATA_WIDTH-1:0] cmd_data;
    logic                                busy;
    logic                                res_valid;
    logic [systolic_pkg::ACC_WIDTH-1:0]  res_data;
    logic [systolic_pkg::ADDR_SIZE-1:0]  res_index;
    logic                                res_last;

    // host-side copies of the loaded matrices, row-major
    logic [7:0] mat_a [systolic_pkg::ELEM_NUM];
    logic [7:0] mat_b [systolic_pkg::ELEM_NUM];
    int errors = 0;
    int mark = 0;
    int passed = 0;
    int failed = 0;
    int cycles = 0;

    systolic_top UUT (.*);

    always #50 s_clk = ~s_clk;

    always @(posedge s_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no end of run after %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // C(i,j) = sum over k of A(i,k) * B(k,j)
    function automatic int unsigned ref_elem(int idx);
        int unsigned sum;
        sum = 0;
        for (int k = 0; k < N; k++) begin
            sum += int'(mat_a[(idx / N) * N + k]) * int'(mat_b[k * N + idx % N]);
        end
        return sum;
    endfunction

    task automatic send_cmd(systolic_pkg::mm_op_e op, int addr, int data);
        @(negedge s_clk);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = systolic_pkg::ADDR_SIZE'(addr);
        cmd_data  = systolic_pkg::DATA_WIDTH'(data);
    endtask

    task automatic load_matrix(systolic_pkg::mm_op_e op);
        for (int idx = 0; idx < systolic_pkg::ELEM_NUM; idx++) begin
            send_cmd(op, idx, (op == systolic_pkg::OP_LOAD_A) ? mat_a[idx] : mat_b[idx]);
        end
        @(negedge s_clk);
        cmd_valid = 1'b0;
    endtask

    task automatic check_quiet(int n);
        repeat (n) begin
            @(negedge s_clk);
            assert (!busy && !res_valid && !res_last) else begin
                $display("busy or result output active while idle");
                errors++;
            end
        end
    endtask

    // with stray set, random commands are thrown at the DUT during the run
    task automatic run_mult(bit stray);
        int count;
        bit seen_last;
        count = 0;
        seen_last = 1'b0;
        send_cmd(systolic_pkg::OP_START, 0, 0);
        @(negedge s_clk);
        cmd_valid = 1'b0;
        while (!seen_last) begin
            @(negedge s_clk);
            cmd_valid = stray;
            cmd_op    = systolic_pkg::mm_op_e'(2'($urandom % 3 + 1));
            cmd_addr  = systolic_pkg::ADDR_SIZE'($urandom);
            cmd_data  = systolic_pkg::DATA_WIDTH'($urandom);
            if (res_valid) begin
                assert (res_index == systolic_pkg::ADDR_SIZE'(count)) else begin
                    $display("Mismatch res_index: got %h expected %h", res_index, count);
                    errors++;
                end
                assert (res_data == systolic_pkg::ACC_WIDTH'(ref_elem(count))) else begin
                    $display("Mismatch res_data index %h: got %h expected %h",
                             count, res_data, ref_elem(count));
                    errors++;
                end
                seen_last = res_last;
                count++;
            end
        end
        cmd_valid = 1'b0;
        assert (count == systolic_pkg::ELEM_NUM) else begin
            $display("result burst ended after %0d results instead of 16", count);
            errors++;
        end
    endtask

    task automatic fill(bit ident_a, bit full_a, bit full_b);
        for (int idx = 0; idx < systolic_pkg::ELEM_NUM; idx++) begin
            mat_a[idx] = ident_a ? 8'(idx / N == idx % N) : (full_a ? 8'hff : 8'($urandom));
            mat_b[idx] = full_b ? 8'hff : 8'($urandom);
        end
    endtask

    task automatic finish_test(string name);
        if (errors == mark) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: FAIL with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        void'($urandom(32'he80b));
        s_rst     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = systolic_pkg::OP_NOP;
        cmd_addr  = '0;
        cmd_data  = '0;
        repeat (3) @(posedge s_clk);
        @(negedge s_clk);
        s_rst = 1'b0;

        check_quiet(5);
        fill(1'b0, 1'b0, 1'b0);
        load_matrix(systolic_pkg::OP_LOAD_A);
        load_matrix(systolic_pkg::OP_LOAD_B);
        run_mult(1'b0);
        check_quiet(3);
        finish_test("test 1 reset state and result framing");

        fill(1'b1, 1'b0, 1'b0);
        load_matrix(systolic_pkg::OP_LOAD_A);
        load_matrix(systolic_pkg::OP_LOAD_B);
        run_mult(1'b0);
        finish_test("test 2 identity A");

        fill(1'b0, 1'b0, 1'b0);
        load_matrix(systolic_pkg::OP_LOAD_A);
        load_matrix(systolic_pkg::OP_LOAD_B);
        run_mult(1'b0);
        fill(1'b0, 1'b1, 1'b1);
        load_matrix(systolic_pkg::OP_LOAD_A);
        load_matrix(systolic_pkg::OP_LOAD_B);
        run_mult(1'b0);
        finish_test("test 3 random and all-255 operands");

        fill(1'b0, 1'b0, 1'b0);
        load_matrix(systolic_pkg::OP_LOAD_A);
        load_matrix(systolic_pkg::OP_LOAD_B);
        run_mult(1'b1);
        check_quiet(40);
        finish_test("test 4 commands ignored while busy");

        // same operands again, then a new B on the old A
        run_mult(1'b0);
        for (int idx = 0; idx < systolic_pkg::ELEM_NUM; idx++) begin
            mat_b[idx] = 8'($urandom);
        end
        load_matrix(systolic_pkg::OP_LOAD_B);
        run_mult(1'b0);
        finish_test("test 5 restart and reload of B");

        assert (UUT.u_props.fail_count == 0) else begin
            $display("%0d bound property checks fired", UUT.u_props.fail_count);
            errors++;
        end
        $display("tests passed %0d failed %0d, errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* systolic_top.f */
design/systolic_pkg.sv
design/mm_cmd_decode.sv
design/slice_feeder.sv
design/pe_array.sv
design/result_drain.sv
design/systolic_top.sv
verification/systolic_properties.sv
verification/systolic_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = systolic_tb
FILELIST = systolic_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
